/* list.f */
l1_cache_pkg.sv
load_align.sv
store_merge.sv
snoop_unit.sv
line_store.sv
cache_ctrl.sv
l1_cache_top.sv
l1_cache_asserts.sv
tb_l1_cache.sv

/* Bender.yml */
package:
  name: l1_cache

sources:
  - files:
      - l1_cache_pkg.sv
      - load_align.sv
      - store_merge.sv
      - snoop_unit.sv
      - line_store.sv
      - cache_ctrl.sv
      - l1_cache_top.sv
  - target: test
    files:
      - l1_cache_asserts.sv
      - tb_l1_cache.sv

/* tb_l1_cache.sv */
`timescale 1ns/1ns

module tb_l1_cache import l1_cache_pkg::*; ();

    localparam int NUM_STEPS = 27;
    localparam int LIMIT     = 16 + 20 * NUM_STEPS;
    localparam logic [6:0] OP_IDLE = 7'b0000000;

    // Test addresses, index in bits 7:2
    localparam logic [ADDR_W-1:0] LINE_A = 32'h0000_1040;  // Index 16
    localparam logic [ADDR_W-1:0] LINE_B = 32'h0000_2084;  // Index 33
    localparam logic [ADDR_W-1:0] LINE_C = 32'h0000_30C0;  // Index 48
    localparam logic [ADDR_W-1:0] LINE_D = 32'h0000_4100;  // Index 0
    localparam logic [ADDR_W-1:0] LINE_X = 32'h0000_5000;  // Index 0, other tag

    logic              clk = 1'b0;
    logic              reset;
    logic [6:0]        opcode_in;
    mask_t             mask_in;
    addr_t             address_in;
    logic [ADDR_W-1:0] data_in;
    logic [ADDR_W-1:0] data_out;
    logic              stall;
    logic              req_core;
    logic              grant;
    bus_op_t           bus_operation_in;
    addr_t             bus_address_in;
    logic [ADDR_W-1:0] bus_data_in;
    logic              cache_hit_in;
    bus_op_t           bus_operation_out;
    logic [ADDR_W-1:0] bus_address_out;
    logic [ADDR_W-1:0] bus_data_out;
    logic              cache_hit_out;
    logic              flush_out;

    // Stimulus and expected values, one entry per step
    string             t_name      [NUM_STEPS];
    logic [6:0]        t_opcode    [NUM_STEPS];
    mask_t             t_mask      [NUM_STEPS];
    logic [ADDR_W-1:0] t_addr      [NUM_STEPS];
    logic [ADDR_W-1:0] t_data      [NUM_STEPS];  // Store data or refill data
    logic              t_grant     [NUM_STEPS];
    bus_op_t           t_bop_in    [NUM_STEPS];
    logic              t_hit_in    [NUM_STEPS];
    logic              t_exp_stall [NUM_STEPS];
    logic [ADDR_W-1:0] t_exp_data  [NUM_STEPS];
    bus_op_t           t_exp_bop   [NUM_STEPS];
    logic              t_exp_hit   [NUM_STEPS];
    logic              t_exp_flush [NUM_STEPS];

    int                n_steps = 0;
    int                errors  = 0;
    int                cycles  = 0;
    int                seed    = 32'h1e29;
    logic [ADDR_W-1:0] rnd_word;

    l1_cache_top #(.NUM_LINES(64)) u_l1_cache_top (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: the test table did not finish within %0d cycles", LIMIT);
            $display("Done: errors found");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic add_row(input string name, input logic [6:0] op, input mask_t mask,
                           input logic [ADDR_W-1:0] addr, input logic [ADDR_W-1:0] data,
                           input logic gnt, input bus_op_t bop_in, input logic hit_in,
                           input logic exp_stall, input logic [ADDR_W-1:0] exp_data,
                           input bus_op_t exp_bop, input logic exp_hit, input logic exp_flush);
        t_name[n_steps]      = name;
        t_opcode[n_steps]    = op;
        t_mask[n_steps]      = mask;
        t_addr[n_steps]      = addr;
        t_data[n_steps]      = data;
        t_grant[n_steps]     = gnt;
        t_bop_in[n_steps]    = bop_in;
        t_hit_in[n_steps]    = hit_in;
        t_exp_stall[n_steps] = exp_stall;
        t_exp_data[n_steps]  = exp_data;
        t_exp_bop[n_steps]   = exp_bop;
        t_exp_hit[n_steps]   = exp_hit;
        t_exp_flush[n_steps] = exp_flush;
        n_steps++;
    endtask

    task automatic load_row(input string name, input mask_t mask, input logic [ADDR_W-1:0] addr,
                            input logic [ADDR_W-1:0] bdata, input logic hit_in,
                            input logic exp_stall, input bus_op_t exp_bop,
                            input logic [ADDR_W-1:0] exp_data);
        add_row(name, OP_LOAD, mask, addr, bdata, 1'b1, BUS_NONE, hit_in, exp_stall, exp_data,
                exp_bop, 1'b0, 1'b0);
    endtask

    task automatic store_row(input string name, input mask_t mask, input logic [ADDR_W-1:0] addr,
                             input logic [ADDR_W-1:0] wdata, input logic gnt,
                             input logic exp_stall, input bus_op_t exp_bop);
        add_row(name, OP_STORE, mask, addr, wdata, gnt, BUS_NONE, 1'b0, exp_stall, '0,
                exp_bop, 1'b0, 1'b0);
    endtask

    task automatic snoop_row(input string name, input bus_op_t bop_in,
                             input logic [ADDR_W-1:0] addr, input logic exp_hit,
                             input logic exp_flush, input logic [ADDR_W-1:0] exp_data);
        add_row(name, OP_IDLE, MASK_W, addr, '0, 1'b1, bop_in, 1'b0, 1'b0, exp_data, BUS_NONE,
                exp_hit, exp_flush);
    endtask

    task automatic build_table();
        snoop_row("idle after reset", BUS_NONE, '0, 1'b0, 1'b0, '0);
        // Exclusive refill, then the load sizes
        load_row("lb refill E", MASK_B, LINE_A, 32'h80F0_7F81, 1'b0, 1'b1, BUS_RD, 32'hFFFF_FF81);
        load_row("lbu hit", MASK_BU, LINE_A, '0, 1'b0, 1'b0, BUS_NONE, 32'h0000_0081);
        load_row("lh offset 2", MASK_H, LINE_A + 2, '0, 1'b0, 1'b0, BUS_NONE, 32'hFFFF_80F0);
        load_row("lw full", MASK_W, LINE_A, '0, 1'b0, 1'b0, BUS_NONE, 32'h80F0_7F81);
        store_row("sw on E", MASK_W, LINE_A, 32'h1234_5678, 1'b1, 1'b0, BUS_NONE);
        store_row("sb offset 3", MASK_B, LINE_A + 3, 32'h0000_00AB, 1'b1, 1'b0, BUS_NONE);
        load_row("lw after sb", MASK_W, LINE_A, '0, 1'b0, 1'b0, BUS_NONE, 32'hAB34_5678);
        store_row("sh offset 0", MASK_H, LINE_A, 32'h0000_CDEF, 1'b1, 1'b0, BUS_NONE);
        load_row("lw after sh", MASK_W, LINE_A, '0, 1'b0, 1'b0, BUS_NONE, 32'hAB34_CDEF);
        store_row("sw random", MASK_W, LINE_A, rnd_word, 1'b1, 1'b0, BUS_NONE);
        load_row("lw random", MASK_W, LINE_A, '0, 1'b0, 1'b0, BUS_NONE, rnd_word);
        store_row("sb miss", MASK_B, LINE_B + 1, 32'h1234_565A, 1'b1, 1'b0, BUS_RDX);
        load_row("lw after sb miss", MASK_W, LINE_B, '0, 1'b0, 1'b0, BUS_NONE, 32'h0000_5A00);
        // Sharers present
        load_row("lw refill S", MASK_W, LINE_C, 32'h0BAD_F00D, 1'b1, 1'b1, BUS_RD, 32'h0BAD_F00D);
        store_row("sw on S", MASK_W, LINE_C, 32'h1111_2222, 1'b1, 1'b0, BUS_UPGR);
        store_row("sw absent", MASK_W, LINE_D, 32'h3333_4444, 1'b1, 1'b0, BUS_RDX);
        // Back-pressure, then the same store granted
        store_row("sw no grant", MASK_W, LINE_A, 32'h7777_8888, 1'b0, 1'b1, BUS_NONE);
        store_row("sw granted", MASK_W, LINE_A, 32'h7777_8888, 1'b1, 1'b0, BUS_NONE);
        load_row("lw after grant", MASK_W, LINE_A, '0, 1'b0, 1'b0, BUS_NONE, 32'h7777_8888);
        snoop_row("snoop rd on M", BUS_RD, LINE_A, 1'b1, 1'b1, 32'h7777_8888);
        store_row("sw after snoop rd", MASK_W, LINE_A, 32'h9999_0000, 1'b1, 1'b0, BUS_UPGR);
        snoop_row("snoop rd absent", BUS_RD, LINE_X, 1'b0, 1'b0, '0);
        // Invalidations force a fresh miss
        snoop_row("snoop rdx on M", BUS_RDX, LINE_C, 1'b1, 1'b1, 32'h1111_2222);
        load_row("lw after rdx", MASK_W, LINE_C, 32'h2222_3333, 1'b0, 1'b1, BUS_RD, 32'h2222_3333);
        snoop_row("snoop upgr on M", BUS_UPGR, LINE_A, 1'b0, 1'b0, '0);
        load_row("lw after upgr", MASK_W, LINE_A, 32'h4444_5555, 1'b0, 1'b1, BUS_RD, 32'h4444_5555);
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [ADDR_W-1:0] expected,
                                   input logic [ADDR_W-1:0] actual);
        errors++;
        $display("[FAIL] %s: %s expected 0x%08h, actual 0x%08h", name, what, expected, actual);
        $display("Done: errors found");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    // Outputs of the request cycle
    task automatic check_first_cycle(input int i);
        logic exp_req;
        // Stores always ask for the bus, loads only on a miss
        exp_req = (t_opcode[i] == OP_STORE) || (t_opcode[i] == OP_LOAD && t_exp_stall[i]);
        assert (stall === t_exp_stall[i])
            else report_mismatch(t_name[i], "stall", t_exp_stall[i], stall);
        assert (bus_operation_out === t_exp_bop[i])
            else report_mismatch(t_name[i], "bus_operation_out", t_exp_bop[i], bus_operation_out);
        if (t_exp_bop[i] != BUS_NONE) begin
            assert (bus_address_out === t_addr[i])
                else report_mismatch(t_name[i], "bus_address_out", t_addr[i], bus_address_out);
        end
        assert (cache_hit_out === t_exp_hit[i])
            else report_mismatch(t_name[i], "cache_hit_out", t_exp_hit[i], cache_hit_out);
        assert (flush_out === t_exp_flush[i])
            else report_mismatch(t_name[i], "flush_out", t_exp_flush[i], flush_out);
        assert (req_core === exp_req)
            else report_mismatch(t_name[i], "req_core", exp_req, req_core);
    endtask

    task automatic check_data(input int i);
        if (t_opcode[i] == OP_LOAD) begin
            assert (data_out === t_exp_data[i])
                else report_mismatch(t_name[i], "data_out", t_exp_data[i], data_out);
        end else if (t_exp_hit[i]) begin
            assert (bus_data_out === t_exp_data[i])
                else report_mismatch(t_name[i], "bus_data_out", t_exp_data[i], bus_data_out);
        end
    endtask

    initial begin
        reset            <= 1'b1;
        opcode_in        <= OP_IDLE;
        mask_in          <= MASK_W;
        address_in       <= '0;
        data_in          <= '0;
        grant            <= 1'b0;
        bus_operation_in <= BUS_NONE;
        bus_address_in   <= '0;
        bus_data_in      <= '0;
        cache_hit_in     <= 1'b0;
        rnd_word = $random(seed);
        build_table();

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < n_steps; i++) begin
            @(posedge clk);
            opcode_in        <= t_opcode[i];
            mask_in          <= t_mask[i];
            address_in       <= t_addr[i];
            data_in          <= t_data[i];
            grant            <= t_grant[i];
            bus_operation_in <= t_bop_in[i];
            bus_address_in   <= t_addr[i];
            bus_data_in      <= t_data[i];
            cache_hit_in     <= t_hit_in[i];
            @(negedge clk);
            check_first_cycle(i);
            // Granted core access, hold until the miss is served
            if (t_grant[i] && t_opcode[i] != OP_IDLE) begin
                while (stall) begin
                    @(negedge clk);
                end
            end
            check_data(i);
        end

        @(posedge clk);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* l1_cache_asserts.sv */
`timescale 1ns/1ns

module l1_cache_asserts import l1_cache_pkg::*; (
    input logic    clk,
    input logic    reset,
    input logic    grant,
    input logic    stall,
    input logic    req_core,
    input bus_op_t bus_operation_out,
    input logic    cache_hit_out,
    input logic    flush_out
);

    // Bus stays quiet until it is ours
    a_no_request_without_grant: assert property (
        @(posedge clk) disable iff (reset) !grant |-> bus_operation_out == BUS_NONE
    ) else $error("Bus request driven while grant is low");

    a_stall_has_request: assert property (
        @(posedge clk) disable iff (reset) stall |-> req_core
    ) else $error("Core stalled without a pending request");

    // A flush only comes with a supplied line
    a_flush_with_hit: assert property (
        @(posedge clk) disable iff (reset) flush_out |-> cache_hit_out
    ) else $error("Flush raised without a snoop hit");

endmodule

bind l1_cache_top l1_cache_asserts u_l1_cache_asserts (
    .clk               (clk),
    .reset             (reset),
    .grant             (grant),
    .stall             (stall),
    .req_core          (req_core),
    .bus_operation_out (bus_operation_out),
    .cache_hit_out     (cache_hit_out),
    .flush_out         (flush_out)
);

/* l1_cache_top.sv */
`timescale 1ns/1ns

module l1_cache_top import l1_cache_pkg::*; #(
    parameter int NUM_LINES = 64
) (
    input  logic              clk,
    input  logic              reset,
    // Core side
    input  logic [6:0]        opcode_in,
    input  mask_t             mask_in,
    input  addr_t             address_in,
    input  logic [ADDR_W-1:0] data_in,
    output logic [ADDR_W-1:0] data_out,
    output logic              stall,
    output logic              req_core,
    // Shared bus
    input  logic              grant,
    input  bus_op_t           bus_operation_in,
    input  addr_t             bus_address_in,
    input  logic [ADDR_W-1:0] bus_data_in,
    input  logic              cache_hit_in,     // Another cache holds the line
    output bus_op_t           bus_operation_out,
    output logic [ADDR_W-1:0] bus_address_out,
    output logic [ADDR_W-1:0] bus_data_out,
    output logic              cache_hit_out,
    output logic              flush_out
);

    logic              core_valid;
    logic              core_tag_match;
    logic              core_hit;
    mesi_t             core_state;
    logic [ADDR_W-1:0] core_word;
    logic              core_we;
    mesi_t             core_wr_state;
    logic              refill_sel;
    logic [ADDR_W-1:0] merged_word;
    logic              snoop_tag_match;
    mesi_t             snoop_state;
    logic [ADDR_W-1:0] snoop_word;
    logic              snoop_we;
    mesi_t             snoop_wr_state;

    assign core_hit = core_valid & core_tag_match;

    cache_ctrl u_cache_ctrl (
        .clk               (clk),
        .reset             (reset),
        .opcode_in         (opcode_in),
        .address_in        (address_in),
        .grant             (grant),
        .cache_hit_in      (cache_hit_in),
        .core_valid        (core_valid),
        .core_tag_match    (core_tag_match),
        .core_state        (core_state),
        .stall             (stall),
        .req_core          (req_core),
        .bus_operation_out (bus_operation_out),
        .bus_address_out   (bus_address_out),
        .refill_sel        (refill_sel),
        .core_we           (core_we),
        .core_wr_state     (core_wr_state)
    );

    line_store #(.NUM_LINES(NUM_LINES)) u_line_store (
        .clk             (clk),
        .reset           (reset),
        .core_addr       (address_in),
        .core_we         (core_we),
        .core_wr_state   (core_wr_state),
        .core_wr_data    (merged_word),
        .snoop_addr      (bus_address_in),
        .snoop_we        (snoop_we),
        .snoop_wr_state  (snoop_wr_state),
        .core_valid      (core_valid),
        .core_tag_match  (core_tag_match),
        .core_state      (core_state),
        .core_word       (core_word),
        .snoop_tag_match (snoop_tag_match),
        .snoop_state     (snoop_state),
        .snoop_word      (snoop_word)
    );

    load_align u_load_align (
        .word     (core_word),
        .offset   (address_in.fields.offset),
        .mask     (mask_in),
        .data_out (data_out)
    );

    store_merge u_store_merge (
        .old_word   (core_word),
        .old_hit    (core_hit),
        .new_data   (data_in),
        .bus_data   (bus_data_in),
        .refill_sel (refill_sel),
        .offset     (address_in.fields.offset),
        .mask       (mask_in),
        .merged     (merged_word)
    );

    snoop_unit u_snoop_unit (
        .bus_operation_in (bus_operation_in),
        .snoop_tag_match  (snoop_tag_match),
        .snoop_state      (snoop_state),
        .snoop_word       (snoop_word),
        .cache_hit_out    (cache_hit_out),
        .bus_data_out     (bus_data_out),
        .flush_out        (flush_out),
        .snoop_we         (snoop_we),
        .snoop_wr_state   (snoop_wr_state)
    );

endmodule

/* cache_ctrl.sv */
`timescale 1ns/1ns

module cache_ctrl import l1_cache_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [6:0]        opcode_in,
    input  addr_t             address_in,
    input  logic              grant,
    input  logic              cache_hit_in,
    input  logic              core_valid,
    input  logic              core_tag_match,
    input  mesi_t             core_state,
    output logic              stall,
    output logic              req_core,
    output bus_op_t           bus_operation_out,
    output logic [ADDR_W-1:0] bus_address_out,
    output logic              refill_sel,     // Take bus data whole
    output logic              core_we,
    output mesi_t             core_wr_state
);

    localparam logic ST_MAIN   = 1'b0;
    localparam logic ST_REFILL = 1'b1;  // Waiting for grant to fill the line

    logic state_q;
    logic state_d;
    logic is_load;
    logic is_store;
    logic hit;

    assign is_load  = (opcode_in == OP_LOAD);
    assign is_store = (opcode_in == OP_STORE);
    assign hit      = core_valid & core_tag_match;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_MAIN;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state, stall and the processor-side MESI request
    always_comb begin
        state_d           = state_q;
        stall             = 1'b0;
        req_core          = 1'b0;
        bus_operation_out = BUS_NONE;
        refill_sel        = 1'b0;
        core_we           = 1'b0;
        core_wr_state     = core_state;

        case (state_q)
            ST_MAIN: begin
                if (is_load && !hit) begin
                    stall    = 1'b1;
                    req_core = 1'b1;
                    state_d  = ST_REFILL;
                    if (grant) begin
                        bus_operation_out = BUS_RD;
                    end
                end else if (is_store) begin
                    req_core = 1'b1;
                    stall    = !grant;  // Hold the core until the bus is ours
                    if (grant) begin
                        core_we       = 1'b1;
                        core_wr_state = MESI_M;
                        if (!hit) begin
                            bus_operation_out = BUS_RDX;   // From I or another tag
                        end else if (core_state == MESI_S) begin
                            bus_operation_out = BUS_UPGR;
                        end
                    end
                end
            end

            ST_REFILL: begin
                stall      = 1'b1;
                req_core   = 1'b1;
                refill_sel = 1'b1;
                if (grant) begin
                    bus_operation_out = BUS_RD;
                    core_we           = 1'b1;
                    // Sharers present means S, else we own it clean
                    core_wr_state     = cache_hit_in ? MESI_S : MESI_E;
                    state_d           = ST_MAIN;
                end
            end

            default: state_d = ST_MAIN;
        endcase
    end

    // Address goes out only with a real request
    assign bus_address_out = (bus_operation_out != BUS_NONE) ? address_in.raw : '0;

endmodule

/* line_store.sv */
`timescale 1ns/1ns

module line_store import l1_cache_pkg::*; #(
    parameter int NUM_LINES = 64
) (
    input  logic              clk,
    input  logic              reset,
    // Core port, lookup and the full line write
    input  addr_t             core_addr,
    input  logic              core_we,
    input  mesi_t             core_wr_state,
    input  logic [ADDR_W-1:0] core_wr_data,
    // Snoop port, lookup and state update
    input  addr_t             snoop_addr,
    input  logic              snoop_we,
    input  mesi_t             snoop_wr_state,
    output logic              core_valid,
    output logic              core_tag_match,
    output mesi_t             core_state,
    output logic [ADDR_W-1:0] core_word,
    output logic              snoop_tag_match,
    output mesi_t             snoop_state,
    output logic [ADDR_W-1:0] snoop_word
);

    localparam int IDX_W  = $clog2(NUM_LINES);
    localparam int LTAG_W = ADDR_W - IDX_W - OFFSET_W;  // Tag grows as lines shrink

    mesi_t             state_mem [NUM_LINES];
    logic [LTAG_W-1:0] tag_mem   [NUM_LINES];
    logic [ADDR_W-1:0] data_mem  [NUM_LINES];

    logic [IDX_W-1:0]  core_idx;
    logic [LTAG_W-1:0] core_tag;
    logic [IDX_W-1:0]  snoop_idx;
    logic [LTAG_W-1:0] snoop_tag;

    assign core_idx  = core_addr.raw[OFFSET_W +: IDX_W];
    assign core_tag  = core_addr.raw[ADDR_W-1 -: LTAG_W];
    assign snoop_idx = snoop_addr.raw[OFFSET_W +: IDX_W];
    assign snoop_tag = snoop_addr.raw[ADDR_W-1 -: LTAG_W];

    assign core_state     = state_mem[core_idx];
    assign core_valid     = (core_state != MESI_I);
    assign core_tag_match = (tag_mem[core_idx] == core_tag);
    assign core_word      = data_mem[core_idx];

    assign snoop_state     = state_mem[snoop_idx];
    assign snoop_tag_match = (tag_mem[snoop_idx] == snoop_tag);
    assign snoop_word      = data_mem[snoop_idx];

    // Core write beats a snoop update in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                state_mem[i] <= MESI_I;
            end
        end else if (core_we) begin
            state_mem[core_idx] <= core_wr_state;
        end else if (snoop_we) begin
            state_mem[snoop_idx] <= snoop_wr_state;  // State only
        end
    end

    always_ff @(posedge clk) begin
        if (core_we) begin
            tag_mem[core_idx]  <= core_tag;
            data_mem[core_idx] <= core_wr_data;
        end
    end

endmodule

/* snoop_unit.sv */
`timescale 1ns/1ns

module snoop_unit import l1_cache_pkg::*; (
    input  bus_op_t           bus_operation_in,
    input  logic              snoop_tag_match,
    input  mesi_t             snoop_state,
    input  logic [ADDR_W-1:0] snoop_word,
    output logic              cache_hit_out,
    output logic [ADDR_W-1:0] bus_data_out,
    output logic              flush_out,
    output logic              snoop_we,
    output mesi_t             snoop_wr_state
);

    logic held;

    // We hold a valid copy of the snooped address
    assign held = snoop_tag_match & (snoop_state != MESI_I);

    always_comb begin
        cache_hit_out  = 1'b0;
        bus_data_out   = '0;
        flush_out      = 1'b0;
        snoop_we       = 1'b0;
        snoop_wr_state = MESI_I;

        if (held) begin
            case (bus_operation_in)
                BUS_RD: begin
                    // Supply the word, drop to shared
                    cache_hit_out  = 1'b1;
                    bus_data_out   = snoop_word;
                    flush_out      = (snoop_state == MESI_M) || (snoop_state == MESI_E);
                    snoop_we       = 1'b1;
                    snoop_wr_state = MESI_S;
                end

                BUS_UPGR: begin
                    snoop_we       = 1'b1;  // Other writer takes it over
                    snoop_wr_state = MESI_I;
                end

                BUS_RDX: begin
                    cache_hit_out  = 1'b1;
                    bus_data_out   = snoop_word;
                    flush_out      = (snoop_state == MESI_M);  // Dirty copy written back
                    snoop_we       = 1'b1;
                    snoop_wr_state = MESI_I;
                end

                default: begin
                    snoop_we = 1'b0;  // Bus idle
                end
            endcase
        end
    end

endmodule

/* store_merge.sv */
`timescale 1ns/1ns

module store_merge import l1_cache_pkg::*; (
    input  logic [ADDR_W-1:0]   old_word,
    input  logic                old_hit,
    input  logic [ADDR_W-1:0]   new_data,
    input  logic [ADDR_W-1:0]   bus_data,
    input  logic                refill_sel,
    input  logic [OFFSET_W-1:0] offset,
    input  mask_t               mask,
    output logic [ADDR_W-1:0]   merged
);

    logic [ADDR_W-1:0] base;

    // Missing line starts from an empty word
    assign base = old_hit ? old_word : '0;

    always_comb begin
        merged = base;
        if (refill_sel) begin
            merged = bus_data;  // Whole line from the bus
        end else begin
            case (mask)
                MASK_B, MASK_BU: begin
                    merged[{offset, 3'b000} +: 8] = new_data[7:0];
                end
                MASK_H, MASK_HU: begin
                    merged[{offset[OFFSET_W-1], 4'b0000} +: 16] = new_data[15:0];
                end
                MASK_W: begin
                    merged = new_data;
                end
                default: ;  // Word left as it was
            endcase
        end
    end

endmodule

/* load_align.sv */
`timescale 1ns/1ns

module load_align import l1_cache_pkg::*; (
    input  logic [ADDR_W-1:0]   word,
    input  logic [OFFSET_W-1:0] offset,
    input  mask_t               mask,
    output logic [ADDR_W-1:0]   data_out
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // Lanes picked by the byte offset
    assign sel_byte = word[{offset, 3'b000} +: 8];
    assign sel_half = word[{offset[OFFSET_W-1], 4'b0000} +: 16];  // Low bit ignored

    always_comb begin
        case (mask)
            MASK_B: begin
                data_out = {{(ADDR_W-8){sel_byte[7]}}, sel_byte};
            end
            MASK_H: begin
                data_out = {{(ADDR_W-16){sel_half[15]}}, sel_half};
            end
            MASK_W: begin
                data_out = word;
            end
            MASK_BU: begin
                data_out = {{(ADDR_W-8){1'b0}}, sel_byte};
            end
            MASK_HU: begin
                data_out = {{(ADDR_W-16){1'b0}}, sel_half};
            end
            default: begin
                data_out = '0;  // Reserved sizes
            end
        endcase
    end

endmodule

/* l1_cache_pkg.sv */
package l1_cache_pkg;

    // Word and line geometry
    localparam int ADDR_W   = 32;  // Address and data width
    localparam int INDEX_W  = 6;   // 64 lines by default
    localparam int OFFSET_W = 2;   // Byte within the word
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // RISC-V major opcodes seen by the cache
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    // Access size, funct3 encoding
    typedef enum logic [2:0] {
        MASK_B  = 3'b000,  // Signed byte
        MASK_H  = 3'b001,  // Signed halfword
        MASK_W  = 3'b010,
        MASK_BU = 3'b100,  // Unsigned byte
        MASK_HU = 3'b101   // Unsigned halfword
    } mask_t;

    typedef enum logic [1:0] {
        MESI_I = 2'b00,
        MESI_E = 2'b01,
        MESI_S = 2'b10,
        MESI_M = 2'b11
    } mesi_t;

    // Shared bus requests, BUS_NONE when idle
    typedef enum logic [1:0] {
        BUS_RD   = 2'b00,
        BUS_UPGR = 2'b01,
        BUS_RDX  = 2'b10,
        BUS_NONE = 2'b11
    } bus_op_t;

    // Address as carried on the bus, or split for the lookup
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
        } fields;
    } addr_t;

endpackage
